// File: logic/simdPkg.sv
/*
 Packed-lane SIMD definitions
 operation codes, the 64-bit lane word and lane constants
 shared by the multiplier, adder and result merge
*/

package simdPkg;

	// lane geometry of one 64-bit word
	localparam int laneCount = 4;
	localparam int laneBits = 16;

	// saturation bounds for one lane
	localparam logic [laneBits-1:0] laneSMax = 16'h7fff;
	localparam logic [laneBits-1:0] laneSMin = 16'h8000;
	localparam logic [laneBits-1:0] laneUMax = 16'hffff;

	// multiply formats sit low, adder codes in the upper half
	// codes not listed here produce a zero result
	typedef enum logic [3:0] {
		opMulLo32   = 4'h1,
		opMulPair   = 4'h3,
		opMulPackLo = 4'h4,
		opMulPackHi = 4'h5,
		opAdd       = 4'h8,
		opSub       = 4'h9,
		opAddSat    = 4'ha,
		opSubSat    = 4'hb
	} simdOp_e;

	// one word seen as four 16-bit lanes or as two 32-bit halves
	// lane A is lanes16[0], bits 15:0
	typedef union packed {
		logic [laneCount-1:0][laneBits-1:0] lanes16;
		logic [1:0][2*laneBits-1:0] words32;
	} laneWord_u;

endpackage

// File: logic/laneMultiplier.sv
/*
 Lane multiplier
 four 16x16 products, signed or unsigned, registered under hold
 also keeps the lane A product widened to 64 bits
*/

`timescale 1ns/1ps

module laneMultiplier
	import simdPkg::*;
(
	input  logic        clock,
	input  logic        rstN,
	input  logic [63:0] valRs,
	input  logic [63:0] valRt,
	input  logic        opUnsigned,
	input  logic        exHold,
	output logic [31:0] prodA,
	output logic [31:0] prodB,
	output logic [31:0] prodC,
	output logic [31:0] prodD,
	output logic [63:0] prodWideLo
);

	// operands stretched to product width
	logic [laneCount-1:0][2*laneBits-1:0] extRs;
	logic [laneCount-1:0][2*laneBits-1:0] extRt;

	// products before the register stage
	logic [laneCount-1:0][2*laneBits-1:0] prodNext;
	logic [63:0] wideNext;

	// sign of the lane A product when widened
	logic wideSign;

	always_comb
	begin
		for (int i = 0; i < laneCount; i++)
		begin
			// zero fill for unsigned, copy msb for signed
			extRs[i] = {
				{laneBits{!opUnsigned && valRs[i*laneBits + laneBits - 1]}},
				valRs[i*laneBits +: laneBits]
			};
			extRt[i] = {
				{laneBits{!opUnsigned && valRt[i*laneBits + laneBits - 1]}},
				valRt[i*laneBits +: laneBits]
			};
			// low 32 bits hold the full 16x16 result either way
			prodNext[i] = extRs[i] * extRt[i];
		end
	end

	// lane A product out to 64 bits
	assign wideSign = !opUnsigned && prodNext[0][2*laneBits-1];
	assign wideNext = {{(64 - 2*laneBits){wideSign}}, prodNext[0]};

	// product registers
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			prodA <= '0;
			prodB <= '0;
			prodC <= '0;
			prodD <= '0;
			prodWideLo <= '0;
		end
		else if (!exHold)
		begin
			prodA <= prodNext[0];
			prodB <= prodNext[1];
			prodC <= prodNext[2];
			prodD <= prodNext[3];
			prodWideLo <= wideNext;
		end
	end

endmodule

// File: logic/laneAdder.sv
/*
 Lane adder
 packed 16-bit add and subtract, wrapping or saturating
 result registered under hold
*/

`timescale 1ns/1ps

module laneAdder
	import simdPkg::*;
(
	input  logic        clock,
	input  logic        rstN,
	input  logic [63:0] valRs,
	input  logic [63:0] valRt,
	input  simdOp_e     opCode,
	input  logic        opUnsigned,
	input  logic        exHold,
	output laneWord_u   sumWord
);

	// operands in lane view
	laneWord_u opRs;
	laneWord_u opRt;
	laneWord_u sumNext;

	// subtract for both subtract codes
	logic isSub;

	assign opRs = valRs;
	assign opRt = valRt;
	assign isSub = (opCode == opSub) || (opCode == opSubSat);

	// clamp one 17-bit lane result to its type range
	function automatic logic [laneBits-1:0] satLane(
		input logic [laneBits:0] wide,
		input logic isUnsigned,
		input logic subtract
	);
		if (isUnsigned)
		begin
			// bit 16 is carry on add, borrow on subtract
			if (!wide[laneBits])
				return wide[laneBits-1:0];
			return subtract ? '0 : laneUMax;
		end
		// signed overflow when the top two bits disagree
		if (wide[laneBits] != wide[laneBits-1])
			return wide[laneBits] ? laneSMin : laneSMax;
		return wide[laneBits-1:0];
	endfunction

	always_comb
	begin : laneMath
		logic [laneBits:0] aExt;
		logic [laneBits:0] bExt;
		logic [laneBits:0] wide;
		sumNext = '0;
		for (int i = 0; i < laneCount; i++)
		begin
			// one extra bit, zero or sign
			aExt = {!opUnsigned && opRs.lanes16[i][laneBits-1], opRs.lanes16[i]};
			bExt = {!opUnsigned && opRt.lanes16[i][laneBits-1], opRt.lanes16[i]};
			wide = isSub ? (aExt - bExt) : (aExt + bExt);
			case (opCode)
				opAdd, opSub:
					sumNext.lanes16[i] = wide[laneBits-1:0];
				opAddSat, opSubSat:
					sumNext.lanes16[i] = satLane(wide, opUnsigned, isSub);
				default:
					sumNext.lanes16[i] = '0;
			endcase
		end
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			sumWord <= '0;
		else if (!exHold)
			sumWord <= sumNext;
	end

endmodule

// File: logic/resultMerge.sv
/*
 Result merge
 registers the issued operation and its strobe
 then picks the destination format from both units
*/

`timescale 1ns/1ps

module resultMerge
	import simdPkg::*;
(
	input  logic        clock,
	input  logic        rstN,
	input  simdOp_e     opCode,
	input  logic        opIssue,
	input  logic        exHold,
	input  logic [31:0] prodA,
	input  logic [31:0] prodB,
	input  logic [31:0] prodC,
	input  logic [31:0] prodD,
	input  logic [63:0] prodWideLo,
	input  laneWord_u   sumWord,
	output logic [63:0] valRn,
	output logic        resValid
);

	// operation in step with the unit registers
	simdOp_e opReg;
	laneWord_u mergeWord;

	// issue is dropped while held
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			opReg <= simdOp_e'(4'h0);
			resValid <= 1'b0;
		end
		else if (!exHold)
		begin
			opReg <= opCode;
			resValid <= opIssue;
		end
	end

	always_comb
	begin
		mergeWord = '0;
		case (opReg)
			opMulLo32:
				mergeWord = prodWideLo;
			// product B in the upper word
			opMulPair:
				mergeWord.words32 = {prodB, prodA};
			opMulPackLo:
				mergeWord.lanes16 = {prodD[15:0], prodC[15:0], prodB[15:0], prodA[15:0]};
			opMulPackHi:
				mergeWord.lanes16 = {prodD[31:16], prodC[31:16], prodB[31:16], prodA[31:16]};
			opAdd, opSub, opAddSat, opSubSat:
				mergeWord = sumWord;
			default:
				mergeWord = '0;
		endcase
	end

	assign valRn = mergeWord;

endmodule

// File: logic/exSimdUnit.sv
/*
 Packed-lane execute stage
 lane multiplier and lane adder side by side
 merged into one 64-bit result after one cycle
*/

`timescale 1ns/1ps

module exSimdUnit
	import simdPkg::*;
(
	input  logic        clock,
	input  logic        rstN,
	input  logic [63:0] valRs,
	input  logic [63:0] valRt,
	input  simdOp_e     opCode,
	input  logic        opUnsigned,
	input  logic        opIssue,
	input  logic        exHold,
	output logic [63:0] valRn,
	output logic        resValid
);

	// registered products
	logic [31:0] prodA;
	logic [31:0] prodB;
	logic [31:0] prodC;
	logic [31:0] prodD;
	logic [63:0] prodWideLo;

	// registered packed sum
	laneWord_u sumWord;

	laneMultiplier i_laneMultiplier (
		.clock      (clock),
		.rstN       (rstN),
		.valRs      (valRs),
		.valRt      (valRt),
		.opUnsigned (opUnsigned),
		.exHold     (exHold),
		.prodA      (prodA),
		.prodB      (prodB),
		.prodC      (prodC),
		.prodD      (prodD),
		.prodWideLo (prodWideLo)
	);

	laneAdder i_laneAdder (
		.clock      (clock),
		.rstN       (rstN),
		.valRs      (valRs),
		.valRt      (valRt),
		.opCode     (opCode),
		.opUnsigned (opUnsigned),
		.exHold     (exHold),
		.sumWord    (sumWord)
	);

	// format select on the registered code
	resultMerge i_resultMerge (
		.clock      (clock),
		.rstN       (rstN),
		.opCode     (opCode),
		.opIssue    (opIssue),
		.exHold     (exHold),
		.prodA      (prodA),
		.prodB      (prodB),
		.prodC      (prodC),
		.prodD      (prodD),
		.prodWideLo (prodWideLo),
		.sumWord    (sumWord),
		.valRn      (valRn),
		.resValid   (resValid)
	);

endmodule

// File: tests/exSimdUnit_assert.sv
/*
 Execute stage assertions
 reset, hold and result-valid timing, bound into the top level
*/

`timescale 1ns/1ps

module exSimdUnitAssert (
	input logic        clock,
	input logic        rstN,
	input logic        opIssue,
	input logic        exHold,
	input logic [63:0] valRn,
	input logic        resValid
);

	// no result while in reset
	resetQuiet: assert property (@(posedge clock) !rstN |-> !resValid)
		else $error("resValid high during reset");

	// held edge leaves both outputs untouched
	holdFrozen: assert property (@(posedge clock) disable iff (!rstN)
		exHold |=> ($stable(valRn) && $stable(resValid)))
		else $error("outputs moved under exHold");

	// valid one cycle after an accepted edge, matching its issue
	validFollows: assert property (@(posedge clock) disable iff (!rstN)
		!exHold |=> (resValid == $past(opIssue)))
		else $error("resValid does not follow accepted opIssue");

endmodule

bind exSimdUnit exSimdUnitAssert i_exSimdUnitAssert (.*);

// File: tests/exSimdUnitTb.sv
/*
 Execute stage testbench
 random operands and codes from a fixed seed, one-cycle reference model
 covers reset, multiply formats, packed add, back-to-back, hold, unused codes
*/

`timescale 1ns/1ps

module exSimdUnitTb
	import simdPkg::*;
;

	// reset 4, then each test plus its drain cycle
	localparam int testCycles = 4 + 301 + 301 + 201 + 201 + 51;
	localparam int cycleLimit = testCycles + 200;

	logic clock;
	logic rstN;
	logic [63:0] valRs;
	logic [63:0] valRt;
	simdOp_e opCode;
	logic opUnsigned;
	logic opIssue;
	logic exHold;
	logic [63:0] valRn;
	logic resValid;

	integer seed;
	int cycles;
	int passes;
	int errs;

	// expectation for the cycle after the last accepted edge
	logic expValid;
	logic [63:0] expVal;
	logic [3:0] expCode;

	// output snapshot for the freeze check
	logic [63:0] lastRn;
	logic lastValid;
	logic heldPrev;

	exSimdUnit i_exSimdUnit (
		.clock      (clock),
		.rstN       (rstN),
		.valRs      (valRs),
		.valRt      (valRt),
		.opCode     (opCode),
		.opUnsigned (opUnsigned),
		.opIssue    (opIssue),
		.exHold     (exHold),
		.valRn      (valRn),
		.resValid   (resValid)
	);

	always #4 clock = ~clock;

	// hard stop
	always @(posedge clock)
	begin
		cycles++;
		if (cycles >= cycleLimit)
		begin
			$display("timeout: run went past its limit of %0d cycles", cycleLimit);
			$display("Testbench failed");
			$finish;
		end
	end

	// expected destination value, straight from the lane rules
	function automatic logic [63:0] modelResult(
		input logic [3:0] code,
		input logic [63:0] rs,
		input logic [63:0] rt,
		input logic uns
	);
		longint a;
		longint b;
		longint s;
		logic [31:0] p [laneCount];
		logic [15:0] lane [laneCount];
		logic [63:0] wideA;
		wideA = '0;
		for (int i = 0; i < laneCount; i++)
		begin
			a = uns ? longint'(rs[i*laneBits +: laneBits])
				: longint'($signed(rs[i*laneBits +: laneBits]));
			b = uns ? longint'(rt[i*laneBits +: laneBits])
				: longint'($signed(rt[i*laneBits +: laneBits]));
			p[i] = a * b;
			// full 64-bit product, sign comes out of longint math
			if (i == 0)
				wideA = a * b;
			s = (code == opSub || code == opSubSat) ? a - b : a + b;
			if (code == opAddSat || code == opSubSat)
			begin
				if (uns)
					s = (s < 0) ? 0 : ((s > 65535) ? 65535 : s);
				else
					s = (s < -32768) ? -32768 : ((s > 32767) ? 32767 : s);
			end
			lane[i] = s[15:0];
		end
		case (code)
			opMulLo32: return wideA;
			opMulPair: return {p[1], p[0]};
			opMulPackLo: return {p[3][15:0], p[2][15:0], p[1][15:0], p[0][15:0]};
			opMulPackHi: return {p[3][31:16], p[2][31:16], p[1][31:16], p[0][31:16]};
			opAdd, opSub, opAddSat, opSubSat: return {lane[3], lane[2], lane[1], lane[0]};
			default: return '0;
		endcase
	endfunction

	// group 0 multiply, 1 adder, 2 any defined, else unused
	function automatic logic [3:0] pickCode(input int group);
		logic [3:0] mulSet [4];
		logic [3:0] badSet [8];
		logic [2:0] r;
		mulSet = '{opMulLo32, opMulPair, opMulPackLo, opMulPackHi};
		badSet = '{4'h0, 4'h2, 4'h6, 4'h7, 4'hc, 4'hd, 4'he, 4'hf};
		r = $random(seed);
		case (group)
			0: return mulSet[r[1:0]];
			1: return {2'b10, r[1:0]};
			2: return r[2] ? mulSet[r[1:0]] : {2'b10, r[1:0]};
			default: return badSet[r];
		endcase
	endfunction

	// random word, lanes optionally forced to boundary values
	function automatic logic [63:0] randOperand(input bit edges);
		logic [63:0] w;
		logic [2:0] pick;
		w = {$random(seed), $random(seed)};
		for (int i = 0; i < laneCount; i++)
		begin
			pick = $random(seed);
			if (edges)
			begin
				case (pick)
					3'd0: w[i*laneBits +: laneBits] = 16'h7fff;
					3'd1: w[i*laneBits +: laneBits] = 16'h8000;
					3'd2: w[i*laneBits +: laneBits] = 16'hffff;
					3'd3: w[i*laneBits +: laneBits] = 16'h0001;
					default: ;
				endcase
			end
		end
		return w;
	endfunction

	task automatic checkZero(input string when);
		if (resValid !== 1'b0 || valRn !== 64'h0)
		begin
			$display("ERR %0t %s: valRn %h resValid %b, expected zero",
				$time, when, valRn, resValid);
			errs++;
		end
		else
			passes++;
	endtask

	// outputs settled since the rising edge, checked at the falling one
	task automatic checkOutputs();
		if (heldPrev && (valRn !== lastRn || resValid !== lastValid))
		begin
			$display("ERR %0t hold: valRn %h resValid %b, expected frozen %h %b",
				$time, valRn, resValid, lastRn, lastValid);
			errs++;
		end
		else if (expValid && (resValid !== 1'b1 || valRn !== expVal))
		begin
			$display("ERR %0t op %h expected %h got %h valid %b",
				$time, expCode, expVal, valRn, resValid);
			errs++;
		end
		else if (!expValid && resValid !== 1'b0)
		begin
			$display("ERR %0t resValid high with no accepted issue", $time);
			errs++;
		end
		else
			passes++;
	endtask

	// one falling edge: check the last result, drive the next op
	task automatic driveCycle(input logic [3:0] code, input bit edges, input logic issue,
		input logic hold);
		logic [63:0] rs;
		logic [63:0] rt;
		logic uns;
		@(negedge clock);
		checkOutputs();
		rs = randOperand(edges);
		rt = randOperand(edges);
		uns = $random(seed);
		lastRn = valRn;
		lastValid = resValid;
		heldPrev = hold;
		valRs = rs;
		valRt = rt;
		opCode = simdOp_e'(code);
		opUnsigned = uns;
		opIssue = issue;
		exHold = hold;
		// a held edge keeps the old expectation
		if (!hold)
		begin
			expValid = issue;
			expVal = modelResult(code, rs, rt, uns);
			expCode = code;
		end
	endtask

	task automatic resetTest();
		int errStart;
		errStart = errs;
		rstN = 1'b0;
		repeat (3)
		begin
			@(negedge clock);
			checkZero("in reset");
		end
		rstN = 1'b1;
		@(negedge clock);
		checkZero("after reset");
		$display("reset test done, %0d errors", errs - errStart);
	endtask

	task automatic runTest(input string name, input int count, input int group,
		input bit edges, input bit issueAll, input bit holds);
		int errStart;
		int holdLeft;
		logic hold;
		logic issue;
		errStart = errs;
		holdLeft = 0;
		for (int n = 0; n < count; n++)
		begin
			hold = 1'b0;
			// start a stall stretch of 1 to 6 cycles now and then
			if (holds && holdLeft == 0 && ($random(seed) & 7) == 0)
				holdLeft = 1 + ({$random(seed)} % 6);
			if (holdLeft > 0)
			begin
				hold = 1'b1;
				holdLeft--;
			end
			// stalled cycles always try to issue
			issue = (issueAll || hold) ? 1'b1 : (($random(seed) & 3) != 0);
			driveCycle(pickCode(group), edges, issue, hold);
		end
		// idle cycle so the last result gets checked
		driveCycle(4'h0, 1'b0, 1'b0, 1'b0);
		$display("%s done, %0d errors", name, errs - errStart);
	endtask

	initial
	begin
		seed = 32'h8a17_6804;
		clock = 1'b0;
		rstN = 1'b0;
		valRs = '0;
		valRt = '0;
		opCode = simdOp_e'(4'h0);
		opUnsigned = 1'b0;
		opIssue = 1'b0;
		exHold = 1'b0;
		cycles = 0;
		passes = 0;
		errs = 0;
		expValid = 1'b0;
		expVal = '0;
		expCode = '0;
		lastRn = '0;
		lastValid = 1'b0;
		heldPrev = 1'b0;
		resetTest();
		runTest("multiply formats", 300, 0, 1'b0, 1'b0, 1'b0);
		runTest("packed add and subtract", 300, 1, 1'b1, 1'b0, 1'b0);
		runTest("back-to-back issue", 200, 2, 1'b1, 1'b1, 1'b0);
		runTest("hold", 200, 2, 1'b1, 1'b0, 1'b1);
		runTest("unused codes", 50, 3, 1'b0, 1'b1, 1'b0);
		$display("checks passed %0d, errors %0d", passes, errs);
		if (errs == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: build.f
logic/simdPkg.sv
logic/laneMultiplier.sv
logic/laneAdder.sv
logic/resultMerge.sv
logic/exSimdUnit.sv
tests/exSimdUnit_assert.sv
tests/exSimdUnitTb.sv
